/* compile.f */
verilog/armCtrlPkg.sv
verilog/instrDecoder.sv
verilog/condUnit.sv
verilog/laneMask.sv
verilog/statusReg.sv
verilog/armController.sv
bench/ctrlChecker.sv
bench/tbController.sv

/* run.sh */
#!/bin/sh
# Build and run with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing -f compile.f --top-module tbController -o simTb &&
./obj_dir/simTb | tee /dev/stderr | grep -q "TEST OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* bench/tbController.sv */
`timescale 1ns/1ps

module tbController;

  localparam int testCount    = 6;
  localparam int instrPerTest = 64;
  localparam int clockPeriod  = 40;
  localparam logic [31:0] nop = 32'hE1A00000;   // MOV r0, r0

  logic        clk;
  logic        arstN;
  logic [31:0] instrD;
  logic [3:0]  aluFlagsE;
  logic [1:0]  aluResultLowE;
  logic        stallE, flushE, stallM, stallW, flushW;
  armCtrlPkg::execCtrlT ctrlE;
  armCtrlPkg::memCtrlT  ctrlM;
  armCtrlPkg::wbCtrlT   ctrlW;
  armCtrlPkg::statusT   statusW;
  logic [6:0]  vectorW;
  logic        pcWrPending;
  integer      seed;
  logic [3:0]  prevFlags;   // ALU values for the instruction now in D
  logic [1:0]  prevAddr;

  armController dut0 (.*);
  ctrlChecker checker0 (.*);

  always #(clockPeriod / 2) clk = ~clk;

  // ====================
  // Stimulus helpers
  // ====================

  // New word in D and ALU results for the word moving into E
  task automatic issue(input logic [31:0] instr, input logic [3:0] flags,
                       input logic [1:0] addr, input logic flush);
    @(posedge clk);
    #2;
    instrD        = instr;
    aluFlagsE     = prevFlags;
    aluResultLowE = prevAddr;
    prevFlags     = flags;
    prevAddr      = addr;
    stallE        = 1'b0;
    flushE        = flush;
  endtask

  task automatic issueRandom(input logic [31:0] instr);
    logic [31:0] r;
    r = $random(seed);
    issue(instr, r[3:0], r[5:4], 1'b0);
  endtask

  // Next word waits in D while E holds its instruction
  task automatic holdStall(input logic [31:0] instr, input int cycles, input logic flush);
    issue(instr, 4'h0, 2'b00, 1'b0);
    stallE = 1'b1;   // instrD and ALU values stay put
    repeat (cycles) begin
      @(posedge clk);
      #2;
    end
    stallE = 1'b0;
    flushE = flush;  // Takes effect at the releasing edge
  endtask

  task automatic drain();
    repeat (5) issue(nop, 4'h0, 2'b00, 1'b0);
  endtask

  // ====================
  // Tests
  // ====================

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    seed = 7;
    clk = 1'b0;
    arstN = 1'b0;
    instrD = nop;
    aluFlagsE = 4'h0;
    aluResultLowE = 2'b00;
    {stallE, flushE, stallM, stallW, flushW} = '0;
    prevFlags = 4'h0;
    prevAddr = 2'b00;
    repeat (5) @(posedge clk);
    #2 arstN = 1'b1;

    checker0.startTest("dpDecode");
    repeat (20) begin
      r  = $random(seed);
      r2 = $random(seed);
      issueRandom({4'hE, 2'b00, r[4], r[3:0], r[5], r2[19:16], r2[15:12],
                   r[4] ? r2[11:0] : {r2[11:5], 1'b0, r2[3:0]}});
    end
    drain();
    checker0.endTest();

    checker0.startTest("condGating");
    for (int c = 0; c < 16; c++) begin
      issueRandom(32'hE1520003);                               // CMP r2, r3
      issueRandom({c[3:0], 8'b0000_1000, 4'd2, 4'd1, 12'h003}); // ADD<c> r1
      issueRandom({c[3:0], 4'b1010, 24'h000010});              // B<c>
    end
    drain();
    checker0.endTest();

    checker0.startTest("flagUpdate");
    repeat (20) begin
      r = $random(seed);
      issueRandom({r[31:28], 3'b001, r[3:0], 1'b1, r[11:8], 4'd4, r[23:12]});
    end
    drain();
    checker0.endTest();

    checker0.startTest("memLanes");
    for (int l = 0; l < 2; l++) begin
      for (int off = 0; off < 4; off++) begin
        issue({4'hE, 3'b010, 4'b1100, l[0], 8'h23, 12'h010}, 4'h0, off[1:0], 1'b0);
        issue({4'hE, 3'b010, 4'b1110, l[0], 8'h23, 12'h010}, 4'h0, off[1:0], 1'b0);
      end
      for (int h = 0; h < 2; h++)
        issue({4'hE, 3'b000, 4'b1110, l[0], 8'h23, 4'h0, 4'b1011, 4'h2},
              4'h0, {h[0], 1'b0}, 1'b0);
    end
    issue(32'hE5123004, 4'h0, 2'b01, 1'b0);   // LDR with U clear
    drain();
    checker0.endTest();

    checker0.startTest("branchPc");
    issue(32'hEA000004, 4'h0, 2'b00, 1'b0);   // B
    issue(32'hE1520003, 4'b0100, 2'b00, 1'b0); // CMP with Z set
    issue(32'h1A000004, 4'h0, 2'b00, 1'b0);   // BNE not taken
    issue(32'h0A000004, 4'h0, 2'b00, 1'b0);   // BEQ taken
    issue(32'hE12FFF13, 4'h0, 2'b00, 1'b0);   // BX r3
    issue(32'hE1A0F003, 4'h0, 2'b00, 1'b0);   // MOV pc, r3
    issue(32'h1081F002, 4'h0, 2'b00, 1'b0);   // ADDNE pc that fails
    drain();
    checker0.endTest();

    checker0.startTest("stallFlushUndef");
    issueRandom(32'hE0811002);
    issueRandom(32'hE0822003);
    holdStall(32'hE2433001, 3, 1'b1);         // SUB immediate held in D and then flushed
    issueRandom(32'hE6000010);                // Media space is undefined
    issueRandom(32'hE8900000);                // LDM is not supported
    drain();
    checker0.endTest();

    checker0.summary();
    if (checker0.errorCount == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog sized from the test lengths with a factor of two margin
  initial begin
    #(testCount * instrPerTest * clockPeriod * 2);
    $display("Watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* bench/ctrlChecker.sv */
`timescale 1ns/1ps

module ctrlChecker
  import armCtrlPkg::*;
(
  input logic        clk,
  input logic        arstN,
  input logic [31:0] instrD,
  input logic [3:0]  aluFlagsE,
  input logic [1:0]  aluResultLowE,
  input logic        stallE,
  input logic        flushE,
  input logic        flushW,
  input execCtrlT    ctrlE,
  input memCtrlT     ctrlM,
  input wbCtrlT      ctrlW,
  input statusT      statusW,
  input logic [6:0]  vectorW,
  input logic        pcWrPending
);

  typedef struct packed {
    logic [3:0] alu;
    logic src, rw, mw, mr, br, bx, fw, pc, isByte, isHalf, undef;
  } refDecT;

  typedef struct packed {
    execCtrlT   e;
    memCtrlT    m;
    wbCtrlT     w;
    logic       setFlags;
    logic [3:0] flags;
    logic       undef;
  } expT;

  string      testName;
  int         errorCount = 0;
  int         checkCount = 0;
  int         testErrors = 0;
  int         testChecks = 0;
  logic       eValid;      // Mirror of the Execute slot
  logic [31:0] eInstr;
  logic [3:0] flagModel;   // Flags in program order
  expT        eExp, mExp, wExp;
  statusT     sExp;

  // ====================
  // Reference model
  // ====================

  function automatic logic condPass(input logic [3:0] c, input logic [3:0] f);
    logic n, z, cy, v, base;
    {n, z, cy, v} = f;
    case (c[3:1])
      3'd0: base = z;
      3'd1: base = cy;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = cy & ~z;
      3'd5: base = (n == v);
      3'd6: base = ~z & (n == v);
      default: base = 1'b1;        // AL and NV as its inverse
    endcase
    return c[0] ? ~base : base;    // Odd codes invert
  endfunction

  function automatic refDecT decodeRef(input logic [31:0] i);
    refDecT d;
    logic [3:0] rd;
    d = '0;
    d.alu = 4'd4;                  // ADD unless data processing
    rd = i[15:12];
    if (i[27:4] == 24'h12FFF1) begin
      d.bx = 1'b1;
    end else if (i[27:22] == 6'd0 && i[7:4] == 4'b1001) begin
      d.rw = 1'b1;                 // MUL
      d.fw = i[20];
      rd = i[19:16];
    end else if (i[27:25] == 3'b000 && i[7:4] == 4'b1011 ||
                 i[27:25] == 3'b010 || i[27:25] == 3'b011 && !i[4]) begin
      d.isHalf = (i[27:25] == 3'b000);
      d.alu = i[23] ? 4'd4 : 4'd2;
      d.src = d.isHalf ? i[22] : !i[25];
      d.rw = i[20];
      d.mr = i[20];
      d.mw = !i[20];
      d.isByte = !d.isHalf && i[22];
    end else if (i[27:25] == 3'b001 || i[27:25] == 3'b000 && !i[4]) begin
      d.alu = i[24:21];
      d.src = i[25];
      d.rw = (i[24:23] != 2'b10);  // Compares write nothing
      d.fw = i[20];
    end else if (i[27:25] == 3'b101) begin
      d.br = 1'b1;
      d.src = 1'b1;
    end else begin
      d.undef = 1'b1;
    end
    d.pc = d.br | d.bx | (d.rw && rd == 4'd15);
    return d;
  endfunction

  function automatic expT refExec(input logic valid, input logic [31:0] i,
                                  input logic [3:0] nzcv, input logic [3:0] aluFlags,
                                  input logic [1:0] addr);
    expT r;
    refDecT d;
    logic p, acc;
    r = '0;
    d = decodeRef(i);
    p = condPass(i[31:28], nzcv);
    acc = d.mw | d.mr;
    if (valid) begin
      r.e = '{aluOpT'(d.alu), d.src, (d.br | d.bx) & p};
      r.m.memWrite = d.mw & p;
      r.m.memtoReg = d.mr;
      r.m.regWrite = d.rw & p;
      r.m.byteMask = !acc ? 4'h0 : d.isByte ? 4'b0001 << addr :
                     d.isHalf ? (addr[1] ? 4'b1100 : 4'b0011) : 4'b1111;
      r.w = '{d.rw & p, d.mr, d.pc & p, d.isByte & d.mr, acc ? addr : 2'b00};
      r.setFlags = d.fw & p;
      r.flags = aluFlags;
      r.undef = d.undef & p;
    end
    return r;
  endfunction

  assign eExp = refExec(eValid, eInstr, flagModel, aluFlagsE, aluResultLowE);

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      {eValid, eInstr, flagModel, mExp, wExp, sExp} <= '0;
    end else begin
      if (!stallE) begin
        eValid <= !flushE;
        eInstr <= instrD;
        mExp   <= eExp;
        if (eExp.setFlags)
          flagModel <= eExp.flags;
      end else
        mExp <= '0;                // Bubble behind a held E
      wExp <= flushW ? '0 : mExp;
      if (wExp.setFlags)
        sExp.nzcv <= wExp.flags;
      sExp.undef <= wExp.undef;
    end
  end

  // ====================
  // Compare and report
  // ====================

  task automatic check(input string what, input logic [15:0] exp, input logic [15:0] act);
    checkCount++;
    testChecks++;
    if (exp !== act) begin
      errorCount++;
      testErrors++;
      $display("Error %s %s expected %h actual %h", testName, what, exp, act);
    end
  endtask

  always @(negedge clk) begin
    refDecT dNow;
    refDecT dExe;
    dNow = decodeRef(instrD);
    dExe = decodeRef(eInstr);
    if (arstN) begin
      check("ctrlE", 16'(eExp.e), 16'(ctrlE));
      check("ctrlM", 16'(mExp.m), 16'(ctrlM));
      check("ctrlW", 16'(wExp.w), 16'(ctrlW));
      check("statusW", 16'(sExp), 16'(statusW));
      check("vectorW", sExp.undef ? 16'h0004 : 16'h0000, 16'(vectorW));
      check("pcWrPending", 16'(dNow.pc | eValid & dExe.pc | mExp.w.pcSrc),
            16'(pcWrPending));
    end
  end

  task automatic startTest(input string name);
    testName = name;
    testErrors = 0;
    testChecks = 0;
  endtask

  task automatic endTest();
    $display("%s: %0d checks, %0d errors", testName, testChecks, testErrors);
  endtask

  task automatic summary();
    $display("Total: %0d checks, %0d errors", checkCount, errorCount);
  endtask

endmodule

/* verilog/armController.sv */
`timescale 1ns/1ps

module armController
  import armCtrlPkg::*;
(
  input  logic        clk,
  input  logic        arstN,
  input  logic [31:0] instrD,
  input  logic [3:0]  aluFlagsE,
  input  logic [1:0]  aluResultLowE,
  input  logic        stallE,
  input  logic        flushE,
  input  logic        stallM,
  input  logic        stallW,
  input  logic        flushW,
  output execCtrlT    ctrlE,
  output memCtrlT     ctrlM,
  output wbCtrlT      ctrlW,
  output statusT      statusW,
  output logic [6:0]  vectorW,
  output logic        pcWrPending
);

  // Pending status update of one instruction
  typedef struct packed {
    logic       setFlags;
    logic [3:0] flags;
    logic       undef;
  } flagUpdT;

  // Fields that ride from Execute to Writeback outside memCtrlT
  typedef struct packed {
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
    flagUpdT    upd;
  } sideT;

  decodeCtrlT decD;
  decodeCtrlT decE;
  statusT     curFlagsE;
  logic       condExE;
  logic       setFlagsE;
  logic [3:0] nextFlagsE;
  logic [3:0] laneMaskE;
  logic       memAccessE;
  memCtrlT    memE;
  sideT       sideE;
  sideT       sideM;
  wbCtrlT     wbM;
  flagUpdT    updW;

  // ==================
  // Decode
  // ==================

  instrDecoder decoder0 (.instr(instrD), .ctrl(decD));

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      decE <= '0;
    end else if (!stallE) begin
      if (flushE)
        decE <= '0;                       // Bubble
      else
        decE <= decD;
    end
  end

  // ==================
  // Execute
  // ==================

  // Youngest older flag setter wins, M before W before the register
  always_comb begin
    curFlagsE = statusW;
    if (sideM.upd.setFlags)
      curFlagsE.nzcv = sideM.upd.flags;
    else if (updW.setFlags)
      curFlagsE.nzcv = updW.flags;
  end

  condUnit cond0 (
    .cond(decE.cond), .flagWrite(decE.flagWrite), .flags(curFlagsE),
    .aluFlags(aluFlagsE), .condEx(condExE), .nextFlags(nextFlagsE), .setFlags(setFlagsE)
  );

  laneMask lane0 (
    .isByte(decE.isByte), .isHalf(decE.isHalf), .addrLow(aluResultLowE), .byteMask(laneMaskE)
  );

  assign memAccessE = decE.memWrite | decE.memtoReg;

  always_comb begin
    ctrlE.aluControl     = decE.aluControl;
    ctrlE.aluSrc         = decE.aluSrc;
    ctrlE.branchTaken    = (decE.branch | decE.bx) & condExE;
    memE.memWrite        = decE.memWrite & condExE;
    memE.memtoReg        = decE.memtoReg;   // Harmless once regWrite is gated
    memE.regWrite        = decE.regWrite & condExE;
    memE.byteMask        = memAccessE ? laneMaskE : 4'b0000;
    sideE.pcSrc          = decE.pcSrc & condExE;
    sideE.loadByte       = decE.isByte & decE.memtoReg;
    sideE.byteOffset     = memAccessE ? aluResultLowE : 2'b00;
    sideE.upd.setFlags   = setFlagsE;
    sideE.upd.flags      = nextFlagsE;
    sideE.upd.undef      = decE.undef & condExE;  // Trap only if it would execute
  end

  // ==================
  // Memory
  // ==================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlM <= '0;
      sideM <= '0;
    end else if (!stallM) begin
      if (stallE) begin                   // E holds, so M takes a bubble
        ctrlM <= '0;
        sideM <= '0;
      end else begin
        ctrlM <= memE;
        sideM <= sideE;
      end
    end
  end

  always_comb begin
    wbM.regWrite   = ctrlM.regWrite;
    wbM.memtoReg   = ctrlM.memtoReg;
    wbM.pcSrc      = sideM.pcSrc;
    wbM.loadByte   = sideM.loadByte;
    wbM.byteOffset = sideM.byteOffset;
  end

  // ==================
  // Writeback
  // ==================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlW <= '0;
      updW  <= '0;
    end else if (!stallW) begin
      if (flushW || stallM) begin         // Flushed, or M not draining
        ctrlW <= '0;
        updW  <= '0;
      end else begin
        ctrlW <= wbM;
        updW  <= sideM.upd;
      end
    end
  end

  statusReg status0 (
    .clk(clk), .arstN(arstN), .enable(!stallW), .setFlags(updW.setFlags),
    .nextFlags(updW.flags), .undef(updW.undef), .status(statusW), .vector(vectorW)
  );

  // Fetch hint, D and E ungated, M already resolved
  assign pcWrPending = decD.pcSrc | decE.pcSrc | sideM.pcSrc;

endmodule

/* verilog/statusReg.sv */
`timescale 1ns/1ps

module statusReg
  import armCtrlPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       enable,     // Writeback advancing
  input  logic       setFlags,
  input  logic [3:0] nextFlags,
  input  logic       undef,
  output statusT     status,
  output logic [6:0] vector
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      status <= '0;
    end else if (enable) begin
      if (setFlags)
        status.nzcv <= nextFlags;
      status.undef <= undef;   // Marks the instruction just retired
    end
  end

  // Trap target while the marker is up
  assign vector = status.undef ? undefVector : 7'd0;

endmodule

/* verilog/laneMask.sv */
`timescale 1ns/1ps

module laneMask
  import armCtrlPkg::*;
(
  input  logic       isByte,
  input  logic       isHalf,
  input  logic [1:0] addrLow,   // Effective address bits 1:0
  output logic [3:0] byteMask
);

  // Little endian lanes, lane 0 is bits 7:0
  always_comb begin
    if (isByte) begin
      byteMask = 4'b0001 << addrLow;      // Single lane
    end else if (isHalf) begin
      // Bit 0 ignored, halves are aligned
      byteMask = addrLow[1] ? maskHighHalf : maskLowHalf;
    end else begin
      byteMask = maskWord;
    end
  end

endmodule

/* verilog/condUnit.sv */
`timescale 1ns/1ps

module condUnit
  import armCtrlPkg::*;
(
  input  condT       cond,
  input  logic       flagWrite,
  input  statusT     flags,      // Program-order flags seen by Execute
  input  logic [3:0] aluFlags,
  output logic       condEx,
  output logic [3:0] nextFlags,
  output logic       setFlags
);

  logic n;
  logic z;
  logic c;
  logic v;

  assign {n, z, c, v} = flags.nzcv;

  // ==================
  // Condition check
  // ==================

  always_comb begin
    case (cond)
      condEq: condEx = z;
      condNe: condEx = !z;
      condCs: condEx = c;
      condCc: condEx = !c;
      condMi: condEx = n;
      condPl: condEx = !n;
      condVs: condEx = v;
      condVc: condEx = !v;
      condHi: condEx = c && !z;
      condLs: condEx = !c || z;
      condGe: condEx = (n == v);
      condLt: condEx = (n != v);
      condGt: condEx = !z && (n == v);
      condLe: condEx = z || (n != v);
      condAl: condEx = 1'b1;
      default: condEx = 1'b0;   // NV never executes
    endcase
  end

  // A failed condition leaves the flags alone
  assign setFlags  = flagWrite & condEx;
  assign nextFlags = setFlags ? aluFlags : flags.nzcv;

endmodule

/* verilog/instrDecoder.sv */
`timescale 1ns/1ps

module instrDecoder
  import armCtrlPkg::*;
(
  input  logic [31:0] instr,
  output decodeCtrlT  ctrl
);

  instrClassT instrClass;
  logic       isMul;
  logic       isHalfSig;
  logic       isBx;
  logic [3:0] rd;

  // ==================
  // Classification
  // ==================

  assign isMul     = (instr[27:22] == 6'b000000) && (instr[7:4] == 4'b1001); // MUL, MLA
  assign isHalfSig = (instr[27:25] == 3'b000) && (instr[7:4] == 4'b1011);    // Unsigned half only
  assign isBx      = (instr[27:4] == 24'h12FFF1);

  // MUL keeps its destination in the Rn slot
  assign rd = isMul ? instr[19:16] : instr[15:12];

  always_comb begin
    instrClass = undefined;
    case (instr[27:25])
      3'b000: begin
        if (isBx)
          instrClass = branchX;
        else if (isMul)
          instrClass = multiply;
        else if (isHalfSig)
          instrClass = loadStoreHalf;
        else if (!instr[4])
          instrClass = dataProc;          // Register, immediate shift
      end
      3'b001: instrClass = dataProc;      // Rotated immediate
      3'b010: instrClass = loadStore;     // Immediate offset
      3'b011: begin
        if (!instr[4])
          instrClass = loadStore;         // Register offset, bit 4 set is media space
      end
      3'b101: instrClass = branch;
      default: instrClass = undefined;    // LDM/STM, coprocessor, SWI
    endcase
  end

  // ==================
  // Control fields
  // ==================

  always_comb begin
    ctrl            = '0;
    ctrl.cond       = condT'(instr[31:28]);
    ctrl.aluControl = aluAdd;             // Address and branch target math
    case (instrClass)
      dataProc: begin
        ctrl.aluControl = aluOpT'(instr[24:21]);
        ctrl.aluSrc     = instr[25];
        ctrl.regWrite   = (instr[24:23] != 2'b10); // TST TEQ CMP CMN
        ctrl.flagWrite  = instr[20];
      end
      multiply: begin
        ctrl.regWrite  = 1'b1;
        ctrl.flagWrite = instr[20];
      end
      loadStore, loadStoreHalf: begin
        ctrl.aluControl = instr[23] ? aluAdd : aluSub;  // U bit
        // I bit has opposite sense in the two forms
        ctrl.aluSrc     = (instrClass == loadStore) ? !instr[25] : instr[22];
        ctrl.regWrite   = instr[20];
        ctrl.memtoReg   = instr[20];
        ctrl.memWrite   = !instr[20];
        ctrl.isByte     = (instrClass == loadStore) && instr[22];
        ctrl.isHalf     = (instrClass == loadStoreHalf);
      end
      branch: begin
        ctrl.aluSrc = 1'b1;               // imm24 offset
        ctrl.branch = 1'b1;
      end
      branchX: ctrl.bx = 1'b1;
      default: ctrl.undef = 1'b1;         // Every write stays off
    endcase
    ctrl.pcSrc = ctrl.branch | ctrl.bx | (ctrl.regWrite && (rd == pcRegIndex));
  end

endmodule

/* verilog/armCtrlPkg.sv */
package armCtrlPkg;

  // ==================
  // Encodings
  // ==================

  // Data-processing opcodes, instr[24:21]
  typedef enum logic [3:0] {
    aluAnd, aluEor, aluSub, aluRsb,
    aluAdd, aluAdc, aluSbc, aluRsc,
    aluTst, aluTeq, aluCmp, aluCmn,
    aluOrr, aluMov, aluBic, aluMvn
  } aluOpT;

  // Condition field, instr[31:28]
  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv
  } condT;

  typedef enum logic [2:0] {
    dataProc, multiply, loadStore, loadStoreHalf,
    branch, branchX, undefined
  } instrClassT;

  // ==================
  // Stage control words
  // ==================

  typedef struct packed {
    aluOpT      aluControl;
    logic       aluSrc;     // Immediate operand B
    logic       regWrite;
    logic       memWrite;
    logic       memtoReg;
    logic       branch;
    logic       bx;
    logic       flagWrite;  // S bit
    logic       pcSrc;      // Writes the PC
    logic       isByte;
    logic       isHalf;
    logic       undef;
    condT       cond;
  } decodeCtrlT;

  typedef struct packed {
    aluOpT      aluControl;
    logic       aluSrc;
    logic       branchTaken;
  } execCtrlT;

  typedef struct packed {
    logic       memWrite;
    logic       memtoReg;
    logic       regWrite;
    logic [3:0] byteMask;
  } memCtrlT;

  typedef struct packed {
    logic       regWrite;
    logic       memtoReg;
    logic       pcSrc;
    logic       loadByte;
    logic [1:0] byteOffset;
  } wbCtrlT;

  typedef struct packed {
    logic [3:0] nzcv;
    logic       undef;
  } statusT;

  localparam logic [3:0] maskWord     = 4'b1111;
  localparam logic [3:0] maskLowHalf  = 4'b0011;
  localparam logic [3:0] maskHighHalf = 4'b1100;
  localparam logic [6:0] undefVector  = 7'h04;   // Undefined instruction entry
  localparam logic [3:0] pcRegIndex   = 4'd15;

endpackage
